//--- source/redmule_cfg_pkg.sv
// Sizes and register map of the matrix-multiply accelerator
// The lane count sets both operand and result word widths
// Register addresses are compared on the full CFG_ADDR_W bits
`default_nettype none

package redmule_cfg_pkg;

  // Engine geometry
  localparam int unsigned NUM_LANES = 4;
  localparam int unsigned LANE_W    = 8;
  localparam int unsigned ACC_W     = 16;
  localparam int unsigned DATA_W    = NUM_LANES * LANE_W;
  localparam int unsigned RESULT_W  = NUM_LANES * ACC_W;

  // Config port
  localparam int unsigned CFG_ADDR_W = 8;
  localparam int unsigned CFG_DATA_W = 32;

  // K and tile counters, so at most 255 MACs per tile and 255 tiles per job
  localparam int unsigned CNT_W = 8;

  // Buffering
  localparam int unsigned OP_FIFO_DEPTH = 4;
  localparam int unsigned Z_FIFO_DEPTH  = 2;

  // Write-only register map
  localparam logic [CFG_ADDR_W-1:0] REG_K_ADDR       = 8'h40;
  localparam logic [CFG_ADDR_W-1:0] REG_TILES_ADDR   = 8'h44;
  localparam logic [CFG_ADDR_W-1:0] REG_TRIGGER_ADDR = 8'h54;

endpackage : redmule_cfg_pkg

`default_nettype wire

//--- source/redmule_types_pkg.sv
// Beat, result and state types shared by the accelerator blocks
// Lane 0 always sits in the least significant bits of a word
`default_nettype none

package redmule_types_pkg;

  // Tag carried with every operand beat
  typedef enum logic [1:0] {
    LOAD_Y = 2'd0,
    LOAD_W = 2'd1,
    MAC    = 2'd2
  } operand_kind_e;

  // Kind in the top two bits, payload below
  typedef struct packed {
    operand_kind_e                       kind;
    logic [redmule_cfg_pkg::DATA_W-1:0]  data;
  } operand_t;

  // Four 16-bit accumulator lanes
  typedef logic [redmule_cfg_pkg::RESULT_W-1:0] result_t;

  // Signed lane values inside the engine
  typedef logic signed [redmule_cfg_pkg::LANE_W-1:0] lane_t;
  typedef logic signed [redmule_cfg_pkg::ACC_W-1:0]  acc_t;

  // Job FSM of the controller
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    RUN  = 2'd1,
    DONE = 2'd2
  } ctrl_state_e;

endpackage : redmule_types_pkg

`default_nettype wire

//--- source/redmule_job_if.sv
// Job control between controller and engine
// start is a single-cycle pulse, enable spans the whole job
`timescale 1ns/1ps
`default_nettype none

interface redmule_job_if;

  import redmule_cfg_pkg::*;

  logic             start;
  logic             enable;
  logic [CNT_W-1:0] k_len;
  logic             tile_done;

  modport ctrl (
    output start,
    output enable,
    output k_len,
    input  tile_done
  );

  modport engine (
    input  start,
    input  enable,
    input  k_len,
    output tile_done
  );

endinterface : redmule_job_if

`default_nettype wire

//--- source/redmule_ctrl.sv
// Config registers and job FSM
// K and tile writes only land while idle, there is no read path
// A trigger with K or tiles at zero is dropped silently
// evt_o is a one-cycle pulse in the cycle after the last tile push
`timescale 1ns/1ps
`default_nettype none

module redmule_ctrl (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  input  logic                                  cfg_req_i,
  input  logic                                  cfg_we_i,
  input  logic [redmule_cfg_pkg::CFG_ADDR_W-1:0] cfg_addr_i,
  input  logic [redmule_cfg_pkg::CFG_DATA_W-1:0] cfg_wdata_i,
  redmule_job_if.ctrl                           job,
  output logic                                  busy_o,
  output logic                                  evt_o
);

  import redmule_cfg_pkg::*;
  import redmule_types_pkg::*;

  ctrl_state_e      state_q;
  ctrl_state_e      state_d;
  logic [CNT_W-1:0] k_q;
  logic [CNT_W-1:0] tiles_q;
  logic [CNT_W-1:0] tile_cnt_q;
  logic             start_q;
  logic             cfg_wr;
  logic             idle;
  logic             trigger;
  logic             last_tile;

  assign cfg_wr = cfg_req_i && cfg_we_i;
  assign idle   = (state_q == IDLE);

  // Job only starts with both sizes programmed
  assign trigger = cfg_wr && idle && (cfg_addr_i == REG_TRIGGER_ADDR) &&
                   (k_q != '0) && (tiles_q != '0);

  assign last_tile = job.tile_done && (tile_cnt_q == tiles_q - 1'b1);

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: if (trigger) state_d = RUN;
      RUN:  if (last_tile) state_d = DONE;
      DONE: state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      start_q <= 1'b0;
    end else begin
      state_q <= state_d;
      start_q <= trigger;
    end
  end

  // Size registers, frozen for the duration of a job
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      k_q     <= '0;
      tiles_q <= '0;
    end else if (cfg_wr && idle) begin
      if (cfg_addr_i == REG_K_ADDR) begin
        k_q <= cfg_wdata_i[CNT_W-1:0];
      end
      if (cfg_addr_i == REG_TILES_ADDR) begin
        tiles_q <= cfg_wdata_i[CNT_W-1:0];
      end
    end
  end

  // Completed tiles of the running job
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tile_cnt_q <= '0;
    end else if (trigger) begin
      tile_cnt_q <= '0;
    end else if (job.tile_done) begin
      tile_cnt_q <= tile_cnt_q + 1'b1;
    end
  end

  assign job.start  = start_q;
  assign job.enable = (state_q == RUN);
  assign job.k_len  = k_q;

  assign busy_o = (state_q == RUN);
  assign evt_o  = (state_q == DONE);

endmodule : redmule_ctrl

`default_nettype wire

//--- source/redmule_fifo.sv
// Synchronous circular FIFO, no bypass from push to pop
// push_ready_o is simply not full, so a full FIFO takes no push
// Storage has no reset, only pointers and count are cleared
`timescale 1ns/1ps
`default_nettype none

module redmule_fifo #(
  parameter int unsigned Width = 32,
  parameter int unsigned Depth = 4
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             push_valid_i,
  output logic             push_ready_o,
  input  logic [Width-1:0] push_data_i,
  output logic             pop_valid_o,
  input  logic             pop_ready_i,
  output logic [Width-1:0] pop_data_o,
  output logic             full_o,
  output logic             empty_o
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  logic [Width-1:0] mem_q [Depth];
  logic [PtrW-1:0]  wr_ptr_q;
  logic [PtrW-1:0]  rd_ptr_q;
  logic [CntW-1:0]  count_q;
  logic             push;
  logic             pop;

  assign full_o       = (count_q == CntW'(Depth));
  assign empty_o      = (count_q == '0);
  assign push_ready_o = !full_o;
  assign pop_valid_o  = !empty_o;
  assign pop_data_o   = mem_q[rd_ptr_q];

  assign push = push_valid_i && push_ready_o;
  assign pop  = pop_valid_o && pop_ready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  // Pointers wrap at Depth, which need not be a power of two
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule : redmule_fifo

`default_nettype wire

//--- source/redmule_engine.sv
// Row of multiply-accumulate lanes with one broadcast weight
// Signed 8-bit operands, 16-bit accumulators that wrap on overflow
// The K-th MAC after LOAD_Y pushes its own sum in the same cycle
// A beat popped together with start already sees the cleared state
`timescale 1ns/1ps
`default_nettype none

module redmule_engine (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  redmule_job_if.engine                job,
  input  logic                         op_valid_i,
  output logic                         op_ready_o,
  input  redmule_types_pkg::operand_t  op_i,
  input  logic                         z_full_i,
  output logic                         z_push_o,
  output redmule_types_pkg::result_t   z_data_o
);

  import redmule_cfg_pkg::*;
  import redmule_types_pkg::*;

  lane_t            w_q;
  lane_t            w_base;
  lane_t            w_d;
  acc_t             acc_q    [NUM_LANES];
  acc_t             acc_base [NUM_LANES];
  acc_t             acc_mac  [NUM_LANES];
  acc_t             acc_d    [NUM_LANES];
  lane_t            x_lane   [NUM_LANES];
  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] cnt_base;
  logic [CNT_W-1:0] cnt_d;
  logic             op_fire;
  logic             is_last;

  // Stall on a full result FIFO so a tile push is never lost
  assign op_ready_o = job.enable && !z_full_i;
  assign op_fire    = op_valid_i && op_ready_o;

  // start wipes the tile state for this cycle already
  assign w_base   = job.start ? '0 : w_q;
  assign cnt_base = job.start ? '0 : cnt_q;
  assign is_last  = (cnt_base == job.k_len - 1'b1);

  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      x_lane[i]   = op_i.data[i*LANE_W +: LANE_W];
      acc_base[i] = job.start ? '0 : acc_q[i];
      acc_mac[i]  = acc_base[i] + x_lane[i] * w_base;
      z_data_o[i*ACC_W +: ACC_W] = acc_mac[i];
    end
  end

  assign z_push_o      = op_fire && (op_i.kind == MAC) && is_last;
  assign job.tile_done = z_push_o;

  always_comb begin
    w_d   = w_base;
    cnt_d = cnt_base;
    for (int i = 0; i < NUM_LANES; i++) begin
      acc_d[i] = acc_base[i];
    end
    if (op_fire) begin
      case (op_i.kind)
        LOAD_Y: begin
          // Bias lanes sign-extended into the accumulators
          for (int i = 0; i < NUM_LANES; i++) begin
            acc_d[i] = x_lane[i];
          end
          cnt_d = '0;
        end
        LOAD_W: w_d = op_i.data[LANE_W-1:0];
        MAC: begin
          for (int i = 0; i < NUM_LANES; i++) begin
            acc_d[i] = acc_mac[i];
          end
          cnt_d = is_last ? '0 : cnt_base + 1'b1;
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    w_q <= w_d;
    for (int i = 0; i < NUM_LANES; i++) begin
      acc_q[i] <= acc_d[i];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

endmodule : redmule_engine

`default_nettype wire

//--- source/redmule_top.sv
// Integer matrix-multiply accelerator, plain valid/ready streams
// Operand beats may be sent before the trigger and wait in the FIFO
// Config writes are strobes with no grant and no read-back
// Result latency depends on back-pressure, use z_valid_o
`timescale 1ns/1ps
`default_nettype none

module redmule_top (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  input  logic                                   cfg_req_i,
  input  logic                                   cfg_we_i,
  input  logic [redmule_cfg_pkg::CFG_ADDR_W-1:0] cfg_addr_i,
  input  logic [redmule_cfg_pkg::CFG_DATA_W-1:0] cfg_wdata_i,
  input  logic                                   in_valid_i,
  output logic                                   in_ready_o,
  input  redmule_types_pkg::operand_kind_e       in_kind_i,
  input  logic [redmule_cfg_pkg::DATA_W-1:0]     in_data_i,
  output logic                                   z_valid_o,
  input  logic                                   z_ready_i,
  output logic [redmule_cfg_pkg::RESULT_W-1:0]   z_data_o,
  output logic                                   busy_o,
  output logic                                   evt_o
);

  import redmule_cfg_pkg::*;
  import redmule_types_pkg::*;

  operand_t in_beat;
  operand_t op_beat;
  logic     op_valid;
  logic     op_ready;
  logic     z_push;
  logic     z_full;
  result_t  z_word;

  redmule_job_if job_if ();

  assign in_beat.kind = in_kind_i;
  assign in_beat.data = in_data_i;

  redmule_ctrl i_ctrl (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .cfg_req_i   ( cfg_req_i   ),
    .cfg_we_i    ( cfg_we_i    ),
    .cfg_addr_i  ( cfg_addr_i  ),
    .cfg_wdata_i ( cfg_wdata_i ),
    .job         ( job_if      ),
    .busy_o      ( busy_o      ),
    .evt_o       ( evt_o       )
  );

  // Operand buffer between the input stream and the engine
  redmule_fifo #(
    .Width ( $bits(operand_t) ),
    .Depth ( OP_FIFO_DEPTH    )
  ) i_op_fifo (
    .clk_i        ( clk_i      ),
    .rst_n_i      ( rst_n_i    ),
    .push_valid_i ( in_valid_i ),
    .push_ready_o ( in_ready_o ),
    .push_data_i  ( in_beat    ),
    .pop_valid_o  ( op_valid   ),
    .pop_ready_i  ( op_ready   ),
    .pop_data_o   ( op_beat    ),
    .full_o       (            ),
    .empty_o      (            )
  );

  redmule_engine i_engine (
    .clk_i      ( clk_i    ),
    .rst_n_i    ( rst_n_i  ),
    .job        ( job_if   ),
    .op_valid_i ( op_valid ),
    .op_ready_o ( op_ready ),
    .op_i       ( op_beat  ),
    .z_full_i   ( z_full   ),
    .z_push_o   ( z_push   ),
    .z_data_o   ( z_word   )
  );

  // Result buffer, its full flag throttles the engine
  redmule_fifo #(
    .Width ( RESULT_W     ),
    .Depth ( Z_FIFO_DEPTH )
  ) i_z_fifo (
    .clk_i        ( clk_i     ),
    .rst_n_i      ( rst_n_i   ),
    .push_valid_i ( z_push    ),
    .push_ready_o (           ),
    .push_data_i  ( z_word    ),
    .pop_valid_o  ( z_valid_o ),
    .pop_ready_i  ( z_ready_i ),
    .pop_data_o   ( z_data_o  ),
    .full_o       ( z_full    ),
    .empty_o      (           )
  );

endmodule : redmule_top

`default_nettype wire

//--- verification/redmule_top_sva.sv
// Protocol checks on the accelerator top-level outputs
// Bound into every redmule_top instance, observes ports only
// All properties are disabled while rst_n_i is low
`timescale 1ns/1ps
`default_nettype none

module redmule_top_sva (
  input wire logic                                 clk_i,
  input wire logic                                 rst_n_i,
  input wire logic                                 busy_o,
  input wire logic                                 evt_o,
  input wire logic                                 z_valid_o,
  input wire logic                                 z_ready_i,
  input wire logic [redmule_cfg_pkg::RESULT_W-1:0] z_data_o
);

  // End-of-job event is a single-cycle pulse
  evt_single_cycle: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) evt_o |=> !evt_o
  ) else $error("evt_o held high for more than one cycle");

  // A stalled result must not change or vanish
  z_held_under_stall: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
      (z_valid_o && !z_ready_i) |=> (z_valid_o && $stable(z_data_o))
  ) else $error("z_data_o changed while stalled by z_ready_i");

  // evt_o only right after busy_o falls
  evt_after_busy: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) evt_o |-> (!busy_o && $past(busy_o))
  ) else $error("evt_o not in the cycle after busy_o fell");

endmodule : redmule_top_sva

bind redmule_top redmule_top_sva i_top_sva (
  .clk_i     ( clk_i     ),
  .rst_n_i   ( rst_n_i   ),
  .busy_o    ( busy_o    ),
  .evt_o     ( evt_o     ),
  .z_valid_o ( z_valid_o ),
  .z_ready_i ( z_ready_i ),
  .z_data_o  ( z_data_o  )
);

`default_nettype wire

//--- verification/redmule_tb.sv
// Pattern-driven testbench for the matrix-multiply accelerator
// Stimulus and expected results come from a pattern file under the project root
// Results are popped under random back-pressure and matched in arrival order
// Inputs change and outputs are sampled on the falling clock edge
`timescale 1ns/1ps
`default_nettype none

module redmule_tb;

  import redmule_cfg_pkg::*;
  import redmule_types_pkg::*;

  localparam string PATTERN_FILE = "verification/redmule_patterns.txt";
  localparam int    CLK_PERIOD   = 4;

  logic                  clk_i       = 1'b0;
  logic                  rst_n_i     = 1'b0;
  logic                  cfg_req_i   = 1'b0;
  logic                  cfg_we_i    = 1'b0;
  logic [CFG_ADDR_W-1:0] cfg_addr_i  = '0;
  logic [CFG_DATA_W-1:0] cfg_wdata_i = '0;
  logic                  in_valid_i  = 1'b0;
  logic                  in_ready_o;
  operand_kind_e         in_kind_i   = LOAD_Y;
  logic [DATA_W-1:0]     in_data_i   = '0;
  logic                  z_valid_o;
  logic                  z_ready_i   = 1'b0;
  logic [RESULT_W-1:0]   z_data_o;
  logic                  busy_o;
  logic                  evt_o;

  integer                seed        = 32'hfb4be774;
  logic [RESULT_W-1:0]   exp_q [$];
  int                    evt_seen    = 0;
  int                    evt_wanted  = 0;
  int                    timeout_ns  = 0;
  logic                  trigger_sent = 1'b0;

  redmule_top dut0 (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .cfg_req_i   ( cfg_req_i   ),
    .cfg_we_i    ( cfg_we_i    ),
    .cfg_addr_i  ( cfg_addr_i  ),
    .cfg_wdata_i ( cfg_wdata_i ),
    .in_valid_i  ( in_valid_i  ),
    .in_ready_o  ( in_ready_o  ),
    .in_kind_i   ( in_kind_i   ),
    .in_data_i   ( in_data_i   ),
    .z_valid_o   ( z_valid_o   ),
    .z_ready_i   ( z_ready_i   ),
    .z_data_o    ( z_data_o    ),
    .busy_o      ( busy_o      ),
    .evt_o       ( evt_o       )
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] want);
    if (got !== want) begin
      $display("Error at %0d ns: %s is %h, expected %h", $time, what, got, want);
      $display("STATUS: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("STATUS: FAIL");
    $fatal(1, "run aborted");
  endtask

  // One config strobe held from one falling edge to the next
  task automatic cfg_write(input logic [CFG_ADDR_W-1:0] addr, input logic [CFG_DATA_W-1:0] data);
    cfg_req_i   = 1'b1;
    cfg_we_i    = 1'b1;
    cfg_addr_i  = addr;
    cfg_wdata_i = data;
    if (addr == REG_TRIGGER_ADDR) begin
      trigger_sent <= 1'b1;
    end
    @(negedge clk_i);
    cfg_req_i   = 1'b0;
    cfg_we_i    = 1'b0;
  endtask

  // Holds the beat until the operand FIFO takes it
  task automatic send_beat(input string kind_name, input logic [DATA_W-1:0] data);
    if (kind_name == "LOAD_Y") begin
      in_kind_i = LOAD_Y;
    end else if (kind_name == "LOAD_W") begin
      in_kind_i = LOAD_W;
    end else if (kind_name == "MAC") begin
      in_kind_i = MAC;
    end else begin
      abort_run({"Unknown operand kind in pattern file: ", kind_name});
    end
    in_valid_i = 1'b1;
    in_data_i  = data;
    while (!in_ready_o) @(negedge clk_i);
    @(negedge clk_i);
    in_valid_i = 1'b0;
  endtask

  // Returns one edge after the event when the FSM is back in IDLE
  task automatic wait_job_end();
    while (!evt_o) @(negedge clk_i);
    evt_wanted++;
    @(negedge clk_i);
  endtask

  always @(negedge clk_i) begin
    if (evt_o) begin
      evt_seen <= evt_seen + 1;
    end
  end

  // Result sink with random z_ready_i
  initial begin
    integer              rnd;
    logic [RESULT_W-1:0] want;
    forever begin
      @(negedge clk_i);
      rnd       = $random(seed);
      z_ready_i = rnd[0];
      // Beats held before the first trigger must not produce a result
      if (rst_n_i && z_valid_o && !trigger_sent) begin
        abort_run("A result appeared before any job was triggered");
      end
      if (rst_n_i && z_valid_o && z_ready_i) begin
        if (exp_q.size() == 0) begin
          abort_run($sformatf("Result %h arrived with nothing expected", z_data_o));
        end
        want = exp_q.pop_front();
        check_value("z_data_o", z_data_o, want);
      end
    end
  end

  initial begin
    wait (timeout_ns != 0);
    #(timeout_ns);
    abort_run($sformatf("Timeout: the run did not finish within %0d ns", timeout_ns));
  end

  initial begin
    integer      fd;
    int          line_count;
    int          n;
    string       line;
    string       cmd;
    string       kind_name;
    logic [63:0] f1;
    logic [63:0] f2;

    line_count = 0;
    fd = $fopen(PATTERN_FILE, "r");
    if (fd == 0) begin
      abort_run({"Cannot open pattern file ", PATTERN_FILE});
    end
    while ($fgets(line, fd) != 0) line_count++;
    $fclose(fd);
    timeout_ns = (line_count + 1) * 200 * CLK_PERIOD;

    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge clk_i);
    check_value("busy_o after reset", 64'(busy_o), 64'd0);
    check_value("evt_o after reset", 64'(evt_o), 64'd0);
    check_value("z_valid_o after reset", 64'(z_valid_o), 64'd0);
    check_value("in_ready_o after reset", 64'(in_ready_o), 64'd1);

    fd = $fopen(PATTERN_FILE, "r");
    while ($fgets(line, fd) != 0) begin
      n = $sscanf(line, "%s", cmd);
      if (n < 1 || cmd.substr(0, 0) == "#") continue;
      if (cmd == "C") begin
        n = $sscanf(line, "%s %h %h", cmd, f1, f2);
        cfg_write(f1[CFG_ADDR_W-1:0], f2[CFG_DATA_W-1:0]);
      end else if (cmd == "I") begin
        n = $sscanf(line, "%s %s %h", cmd, kind_name, f1);
        send_beat(kind_name, f1[DATA_W-1:0]);
      end else if (cmd == "E") begin
        n = $sscanf(line, "%s %h", cmd, f1);
        exp_q.push_back(f1);
      end else if (cmd == "R") begin
        n = $sscanf(line, "%s %h", cmd, f1);
        check_value("in_ready_o", 64'(in_ready_o), 64'(f1[0]));
      end else if (cmd == "B") begin
        n = $sscanf(line, "%s %h", cmd, f1);
        check_value("busy_o", 64'(busy_o), 64'(f1[0]));
      end else if (cmd == "V") begin
        wait_job_end();
      end else begin
        abort_run({"Unknown command in pattern file: ", line});
      end
    end
    $fclose(fd);

    while (exp_q.size() != 0) @(negedge clk_i);
    repeat (20) @(negedge clk_i);
    check_value("end-of-job event count", 64'(evt_seen), 64'(evt_wanted));
    $display("STATUS: PASS");
    $finish;
  end

endmodule : redmule_tb

`default_nettype wire

//--- verification/redmule_patterns.txt
# Columns: command then hex fields. C addr data is a config write, I kind data an operand beat
# E data queues an expected result, R and B check in_ready_o and busy_o, V waits for evt_o
# Holding before the trigger, then one tile with K=3 and an overflowing lane
C 40 3
C 44 1
I LOAD_Y 7F64FB0A
I LOAD_W 00000080
I MAC 8003FE01
R 1
I MAC 80FF0002
R 0
E C07FFF64FE7BFC8A
C 54 1
B 1
I MAC 80000504
V
B 0
# Weight change inside a tile with K=4
C 40 4
C 54 1
B 1
E FFFD000BFFF90004
I LOAD_Y 04030201
I LOAD_W 00000002
I MAC 01010101
I MAC 0003FF02
I LOAD_W 000000FD
I MAC 05FF0201
I MAC FE010100
V
B 0
# Three tiles with K=2, the K write while busy is ignored
C 40 2
C 44 3
C 54 1
B 1
C 40 1
E 000F000A00050000
I LOAD_Y 00000000
I LOAD_W 00000005
I MAC 04030201
I MAC FFFFFFFF
B 1
E FFD6FFE0FFEAFFF4
I LOAD_Y FFFFFFFF
I LOAD_W 000000FF
I MAC 281E140A
I MAC 01010101
B 1
E 013E0030FFA17E12
I LOAD_Y 40302010
I LOAD_W 0000007F
I MAC 0100807F
I MAC 01007F7F
V
B 0
# Triggers with K=0 or tiles=0 start nothing
C 40 0
C 54 1
B 0
C 40 2
C 44 0
C 54 1
B 0

//--- filelist.f
source/redmule_cfg_pkg.sv
source/redmule_types_pkg.sv
source/redmule_job_if.sv
source/redmule_ctrl.sv
source/redmule_fifo.sv
source/redmule_engine.sv
source/redmule_top.sv
verification/redmule_top_sva.sv
verification/redmule_tb.sv

//--- run_verilator.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module redmule_tb -f filelist.f -Mdir obj_dir -o redmule_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/redmule_sim 2>&1)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if ! echo "$sim_out" | grep -qx "STATUS: PASS"; then
  echo "Pass message not found in simulation output"
  exit 1
fi

exit 0
